//--- Bender.yml
package:
  name: wisc_fetch

sources:
  - include_dirs:
      - design
    files:
      - design/isaPkg.sv
      - design/pipePkg.sv
      - design/programCounter.sv
      - design/memArbiter.sv
      - design/unifiedMemory.sv
      - design/instrDecode.sv
      - design/hazardDetect.sv
      - design/fetchStage.sv
  - target: simulation
    files:
      - sim/fetchStageTb.sv

//--- build.f
+incdir+design
design/isaPkg.sv
design/pipePkg.sv
design/programCounter.sv
design/memArbiter.sv
design/unifiedMemory.sv
design/instrDecode.sv
design/hazardDetect.sv
design/fetchStage.sv
sim/fetchStageTb.sv

//--- design/fetchStage.sv
// Instruction fetch stage
`timescale 1ns/10ps
`default_nettype none
`include "wisc_consts.svh"

module fetchStage (
    input wire clk,
    input wire reset,
    input wire dataReq,
    input wire dataWr,
    input wire [`WISC_WORD_W-1:0] dataAddr,
    input wire [`WISC_WORD_W-1:0] dataWrData,
    output logic [`WISC_WORD_W-1:0] dataRdData,
    output logic dataRdValid,
    input wire pcSel,
    input wire [`WISC_WORD_W-1:0] brnchAddr,
    output logic [`WISC_WORD_W-1:0] instr,
    output logic [`WISC_WORD_W-1:0] pc,
    output logic instrValid,
    output logic regWrite,
    output logic [`WISC_REG_W-1:0] writeRegAddr,
    output logic memEnable,
    output logic memWr,
    output logic val2Reg,
    output logic [2:0] immSel,
    output logic ctrlErr,
    output logic halt
);
    import pipePkg::*;

    logic [`WISC_WORD_W-1:0] fetchAddr, memAddr, memWrData, memRdData;
    logic [`WISC_WORD_W-1:0] retPcQ, heldWord, heldPc, bufWord;
    logic [`WISC_REG_W-1:0] chkWrAddr;
    logic fetchReq, memEn, memWe, fetchTaken;
    logic retValidQ, heldQ, bufFull, bubble, emit;
    logic chkRegWrite, readsRs, readsRt;
    grantT grant;

    programCounter pc_i (
        .clk(clk), .reset(reset), .pcSel(pcSel), .brnchAddr(brnchAddr),
        .stall(bubble), .halt(halt), .fetchGrant(grant == GRANT_FETCH),
        .pc(fetchAddr), .fetchReq(fetchReq)
    );

    memArbiter arb_i (
        .dataReq(dataReq), .dataWr(dataWr), .dataAddr(dataAddr), .dataWrData(dataWrData),
        .fetchReq(fetchReq), .fetchAddr(fetchAddr), .memEn(memEn), .memWe(memWe),
        .memAddr(memAddr), .memWrData(memWrData), .grant(grant)
    );

    unifiedMemory mem_i (
        .clk(clk), .memEn(memEn), .memWe(memWe), .memAddr(memAddr),
        .memWrData(memWrData), .memRdData(memRdData)
    );

    // Fetch lands in memRdData next cycle, a stalled word moves to heldWord
    assign fetchTaken = (grant == GRANT_FETCH) && !bubble;
    assign bufFull    = heldQ || retValidQ;
    assign bufWord    = heldQ ? heldWord : memRdData;
    assign pc         = heldQ ? heldPc : retPcQ;
    assign instr      = emit ? bufWord : `WISC_NOP_WORD;  // Bubbles decode as NOP
    assign instrValid = emit;
    assign dataRdData = memRdData;

    always_ff @(posedge clk) begin
        if (reset) begin
            retValidQ   <= 1'b0;
            heldQ       <= 1'b0;
            dataRdValid <= 1'b0;
        end else begin
            retValidQ   <= fetchTaken;
            heldQ       <= bubble && !pcSel;
            dataRdValid <= dataReq && !dataWr;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchTaken) begin
            retPcQ <= fetchAddr + 'd2;
        end
        if (!heldQ) begin
            heldWord <= memRdData;
            heldPc   <= retPcQ;
        end
    end

    // Outputs come from the gated word
    instrDecode dec_i (
        .instr(instr), .regWrite(regWrite), .destSel(), .writeRegAddr(writeRegAddr),
        .memEnable(memEnable), .memWr(memWr), .val2Reg(val2Reg), .immSel(immSel),
        .readsRs(), .readsRt(), .halt(halt), .ctrlErr(ctrlErr)
    );

    // Raw buffer decode for the hazard check
    instrDecode chk_i (
        .instr(bufWord), .regWrite(chkRegWrite), .destSel(), .writeRegAddr(chkWrAddr),
        .memEnable(), .memWr(), .val2Reg(), .immSel(),
        .readsRs(readsRs), .readsRt(readsRt), .halt(), .ctrlErr()
    );

    hazardDetect hdu_i (
        .clk(clk), .reset(reset), .instrFull(bufFull), .pcSel(pcSel),
        .srcRs(bufWord[10:8]), .srcRt(bufWord[7:5]), .readsRs(readsRs), .readsRt(readsRt),
        .regWrite(chkRegWrite), .writeRegAddr(chkWrAddr), .bubble(bubble), .emit(emit)
    );

endmodule

`default_nettype wire

//--- design/hazardDetect.sv
// Read-after-write hazard unit
`timescale 1ns/10ps
`default_nettype none
`include "wisc_consts.svh"

module hazardDetect (
    input wire clk,
    input wire reset,
    input wire instrFull,
    input wire pcSel,
    input wire [`WISC_REG_W-1:0] srcRs,
    input wire [`WISC_REG_W-1:0] srcRt,
    input wire readsRs,
    input wire readsRt,
    input wire regWrite,
    input wire [`WISC_REG_W-1:0] writeRegAddr,
    output logic bubble,
    output logic emit
);
    // Entry 0 is last cycle's emission, entry 1 the one before
    logic [1:0] histWe;
    logic [`WISC_REG_W-1:0] histAddr [2];
    logic [1:0] hit;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            hit[i] = histWe[i] &&
                     ((readsRs && srcRs == histAddr[i]) ||
                      (readsRt && srcRt == histAddr[i]));
        end
    end

    assign bubble = instrFull && |hit;
    assign emit   = instrFull && !(|hit) && !pcSel;  // Redirect squashes the word

    // Cycles without an emission push an empty entry
    always_ff @(posedge clk) begin
        if (reset) begin
            histWe <= '0;
        end else begin
            histWe <= {histWe[0], emit && regWrite};
        end
    end

    always_ff @(posedge clk) begin
        histAddr[0] <= writeRegAddr;
        histAddr[1] <= histAddr[0];
    end

    bubbleXorEmit: assert property (@(posedge clk) disable iff (reset)
        !(bubble && emit))
        else $error("Hazard unit stalled and released the same instruction");

endmodule

`default_nettype wire

//--- design/instrDecode.sv
// Instruction decoder
`timescale 1ns/10ps
`default_nettype none
`include "wisc_consts.svh"

module instrDecode (
    input wire [`WISC_WORD_W-1:0] instr,
    output logic regWrite,
    output isaPkg::destSelT destSel,
    output logic [`WISC_REG_W-1:0] writeRegAddr,
    output logic memEnable,
    output logic memWr,
    output logic val2Reg,
    output logic [2:0] immSel,
    output logic readsRs,
    output logic readsRt,
    output logic halt,
    output logic ctrlErr
);
    import isaPkg::*;

    // Immediate formats for the execute stage
    localparam logic [2:0] immNone = 3'b000;
    localparam logic [2:0] immI5   = 3'b001;  // Sign-extended instr[4:0]
    localparam logic [2:0] immI8   = 3'b010;  // Sign-extended instr[7:0]
    localparam logic [2:0] immJ11  = 3'b011;  // Sign-extended instr[10:0]

    opcodeT op;

    assign op = opcodeT'(instr[15:11]);

    always_comb begin
        regWrite  = 1'b0;
        destSel   = RS_FIELD;
        memEnable = 1'b0;
        memWr     = 1'b0;
        val2Reg   = 1'b0;
        immSel    = immNone;
        readsRs   = 1'b0;
        readsRt   = 1'b0;
        halt      = 1'b0;
        ctrlErr   = 1'b0;
        case (op)
            OP_HALT: halt = 1'b1;
            OP_NOP: ;
            OP_ADDI, OP_SUBI: begin
                regWrite = 1'b1;
                destSel  = RD_I_FIELD;
                immSel   = immI5;
                readsRs  = 1'b1;
            end
            OP_ST: begin
                memEnable = 1'b1;
                memWr     = 1'b1;
                immSel    = immI5;
                readsRs   = 1'b1;
                readsRt   = 1'b1;  // Store data lives in instr[7:5]
            end
            OP_LD: begin
                regWrite  = 1'b1;
                destSel   = RD_I_FIELD;
                memEnable = 1'b1;
                val2Reg   = 1'b1;  // Writeback takes memory data
                immSel    = immI5;
                readsRs   = 1'b1;
            end
            OP_BEQZ, OP_BNEZ: begin
                immSel  = immI8;
                readsRs = 1'b1;
            end
            OP_J: immSel = immJ11;
            OP_JAL: begin
                regWrite = 1'b1;
                destSel  = LINK;
                immSel   = immJ11;
            end
            OP_RTYPE: begin
                regWrite = 1'b1;
                destSel  = RD_R_FIELD;
                readsRs  = 1'b1;
                readsRt  = 1'b1;
            end
            default: ctrlErr = 1'b1;  // Enables stay low
        endcase
    end

    always_comb begin
        case (destSel)
            RS_FIELD:   writeRegAddr = instr[10:8];
            RD_R_FIELD: writeRegAddr = instr[4:2];
            LINK:       writeRegAddr = `WISC_LINK_REG;
            RD_I_FIELD: writeRegAddr = instr[7:5];
            default:    writeRegAddr = instr[4:2];
        endcase
    end

endmodule

`default_nettype wire

//--- design/isaPkg.sv
// Instruction set types
`default_nettype none

package isaPkg;

    // Opcode is instr[15:11]
    // Only the supported subset is listed, anything else decodes as an error
    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_J     = 5'b00100,  // PC-relative jump, 11-bit displacement
        OP_JAL   = 5'b00110,  // Jump and link to R7
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_BEQZ  = 5'b01100,
        OP_BNEZ  = 5'b01101,
        OP_ST    = 5'b10000,  // mem[Rs + imm] = Rd
        OP_LD    = 5'b10001,  // Rd = mem[Rs + imm]
        OP_RTYPE = 5'b11011   // ADD, SUB, XOR, ANDN group
    } opcodeT;

    // Where the destination register number comes from
    typedef enum logic [1:0] {
        RS_FIELD   = 2'b00,  // instr[10:8]
        RD_R_FIELD = 2'b01,  // instr[4:2]
        LINK       = 2'b10,  // Fixed R7
        RD_I_FIELD = 2'b11   // instr[7:5]
    } destSelT;

endpackage

`default_nettype wire

//--- design/memArbiter.sv
// Memory port arbiter
`timescale 1ns/10ps
`default_nettype none
`include "wisc_consts.svh"

module memArbiter (
    input wire dataReq,
    input wire dataWr,
    input wire [`WISC_WORD_W-1:0] dataAddr,
    input wire [`WISC_WORD_W-1:0] dataWrData,
    input wire fetchReq,
    input wire [`WISC_WORD_W-1:0] fetchAddr,
    output logic memEn,
    output logic memWe,
    output logic [`WISC_WORD_W-1:0] memAddr,
    output logic [`WISC_WORD_W-1:0] memWrData,
    output pipePkg::grantT grant
);
    import pipePkg::*;

    // Data port always wins, fetch just retries
    always_comb begin
        if (dataReq) begin
            grant = GRANT_DATA;
        end else if (fetchReq) begin
            grant = GRANT_FETCH;
        end else begin
            grant = GRANT_NONE;
        end
    end

    assign memEn     = grant != GRANT_NONE;
    assign memWe     = dataReq && dataWr;  // Fetch side is read-only
    assign memAddr   = (grant == GRANT_DATA) ? dataAddr : fetchAddr;
    assign memWrData = (grant == GRANT_DATA) ? dataWrData : '0;

    writeOnlyFromData: assert final (!memWe || grant == GRANT_DATA)
        else $error("Memory write issued without a data-port grant");

endmodule

`default_nettype wire

//--- design/pipePkg.sv
// Fetch pipeline types
`default_nettype none

package pipePkg;

    // Owner of the memory port this cycle
    typedef enum logic [1:0] {
        GRANT_NONE  = 2'd0,
        GRANT_DATA  = 2'd1,
        GRANT_FETCH = 2'd2
    } grantT;

    // Next PC choice, highest priority first is redirect
    typedef enum logic [1:0] {
        PC_SEQ      = 2'd0,
        PC_HOLD     = 2'd1,
        PC_REDIRECT = 2'd2,
        PC_HALT     = 2'd3
    } pcSrcT;

endpackage

`default_nettype wire

//--- design/programCounter.sv
// Program counter
`timescale 1ns/10ps
`default_nettype none
`include "wisc_consts.svh"

module programCounter (
    input wire clk,
    input wire reset,
    input wire pcSel,
    input wire [`WISC_WORD_W-1:0] brnchAddr,
    input wire stall,
    input wire halt,
    input wire fetchGrant,
    output logic [`WISC_WORD_W-1:0] pc,
    output logic fetchReq
);
    import pipePkg::*;

    pcSrcT pcSrc;
    logic haltedQ;  // Sticky until reset

    always_comb begin
        if (pcSel) begin
            pcSrc = PC_REDIRECT;
        end else if (halt || haltedQ) begin
            pcSrc = PC_HALT;
        end else if (stall || !fetchGrant) begin
            pcSrc = PC_HOLD;  // Bubble or lost arbitration, retry same address
        end else begin
            pcSrc = PC_SEQ;
        end
    end

    // No fetch while redirecting or once halted
    assign fetchReq = !pcSel && !halt && !haltedQ;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= '0;
            haltedQ <= 1'b0;
        end else begin
            if (halt) begin
                haltedQ <= 1'b1;
            end
            case (pcSrc)
                PC_REDIRECT: pc <= brnchAddr;
                PC_SEQ:      pc <= pc + 'd2;  // Word-aligned byte address
                default:     pc <= pc;
            endcase
        end
    end

    pcHoldsOnStall: assert property (@(posedge clk) disable iff (reset)
        (stall && !pcSel) |=> $stable(pc))
        else $error("PC advanced while the hazard unit was stalling");

endmodule

`default_nettype wire

//--- design/unifiedMemory.sv
// Unified instruction and data memory
`timescale 1ns/10ps
`default_nettype none
`include "wisc_consts.svh"

module unifiedMemory (
    input wire clk,
    input wire memEn,
    input wire memWe,
    input wire [`WISC_WORD_W-1:0] memAddr,
    input wire [`WISC_WORD_W-1:0] memWrData,
    output logic [`WISC_WORD_W-1:0] memRdData
);
    localparam int idxW = $clog2(`WISC_MEM_WORDS);

    logic [`WISC_WORD_W-1:0] mem [`WISC_MEM_WORDS];
    logic [idxW-1:0] wordIdx;

    // Byte address to word index, bit 0 ignored
    assign wordIdx = memAddr[idxW:1];

    always_ff @(posedge clk) begin
        if (memEn) begin
            if (memWe) begin
                mem[wordIdx] <= memWrData;
            end else begin
                memRdData <= mem[wordIdx];  // Read data holds between accesses
            end
        end
    end

endmodule

`default_nettype wire

//--- design/wisc_consts.svh
// WISC fetch constants
`ifndef WISC_CONSTS_SVH
`define WISC_CONSTS_SVH

// Instruction, address and data width
`define WISC_WORD_W 16

// Register file address width
`define WISC_REG_W 3

// Unified memory depth in 16-bit words
`define WISC_MEM_WORDS 256

// NOP opcode with all fields zero, used as the bubble word
`define WISC_NOP_WORD 16'h0800

// JAL writes its return address here
`define WISC_LINK_REG 3'd7

`endif

//--- sim/fetchStageTb.sv
// Fetch stage testbench
`timescale 1ns/10ps
`default_nettype none

module fetchStageTb;
    import isaPkg::*;

    localparam int lenData  = 38;  // Data-port operations in the first test
    localparam int lenIndep = 10;
    localparam int lenDep   = 8;
    localparam int lenRedir = 24;
    localparam int lenHalt  = 5;
    localparam int runCycles = (lenData + lenIndep + lenDep + lenRedir + lenHalt) * 4 + 200;

    logic clk, reset, dataReq, dataWr, pcSel;
    logic [15:0] dataAddr, dataWrData, brnchAddr;
    logic [15:0] dataRdData, instr, pc;
    logic [2:0] writeRegAddr, immSel;
    logic dataRdValid, instrValid, regWrite, memEnable, memWr, val2Reg, ctrlErr, halt;

    // Expected values for the current cycle are set on the falling edge
    logic checkOn, expValid, expRegWrite, expHalt, expCtrlErr, expMemEn, expMemWr;
    logic expVal2Reg;
    logic [15:0] expPc, expInstr, rdExpect;
    logic [2:0] expDest, expImmSel;
    logic quietPhase, dataPhase;

    logic [15:0] shadow [256];
    logic [15:0] prog [$];
    int expQ [$];  // Word index per cycle with -1 for idle and -2 for redirect
    logic hWe [2];
    logic [2:0] hA [2];
    int errCount, testCount;

    fetchStage fetchStage_i (
        .clk(clk), .reset(reset), .dataReq(dataReq), .dataWr(dataWr), .dataAddr(dataAddr),
        .dataWrData(dataWrData), .dataRdData(dataRdData), .dataRdValid(dataRdValid),
        .pcSel(pcSel), .brnchAddr(brnchAddr), .instr(instr), .pc(pc),
        .instrValid(instrValid), .regWrite(regWrite), .writeRegAddr(writeRegAddr),
        .memEnable(memEnable), .memWr(memWr), .val2Reg(val2Reg), .immSel(immSel),
        .ctrlErr(ctrlErr), .halt(halt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    quietAfterReset: assert property (@(posedge clk) disable iff (reset)
        quietPhase |-> !instrValid && !dataRdValid && !regWrite && !memWr && !halt)
        else begin
            errCount++;
            $display("MISMATCH @%0t: output active before the first instruction", $time);
        end

    noFetchDuringData: assert property (@(posedge clk) disable iff (reset)
        dataPhase |-> !instrValid)
        else begin
            errCount++;
            $display("MISMATCH @%0t: instruction emitted while the data port was busy", $time);
        end

    readReturns: assert property (@(posedge clk) disable iff (reset)
        (dataReq && !dataWr) |=> (dataRdValid && dataRdData == $past(rdExpect)))
        else begin
            errCount++;
            $display("MISMATCH @%0t: read data %h valid %b, expected %h", $time,
                     $sampled(dataRdData), $sampled(dataRdValid), $past(rdExpect));
        end

    readValidOnce: assert property (@(posedge clk) disable iff (reset)
        !(dataReq && !dataWr) |=> !dataRdValid)
        else begin
            errCount++;
            $display("MISMATCH @%0t: dataRdValid high without a read", $time);
        end

    validMatches: assert property (@(posedge clk) disable iff (reset)
        checkOn |-> instrValid == expValid)
        else begin
            errCount++;
            $display("MISMATCH @%0t: instrValid %b, expected %b", $time,
                     $sampled(instrValid), $sampled(expValid));
        end

    fieldsMatch: assert property (@(posedge clk) disable iff (reset)
        (checkOn && expValid) |-> pc == expPc && instr == expInstr &&
            regWrite == expRegWrite && (!expRegWrite || writeRegAddr == expDest))
        else begin
            errCount++;
            $display("MISMATCH @%0t: pc %h instr %h rw %b dst %0d, expected %h %h %b %0d",
                     $time, $sampled(pc), $sampled(instr), $sampled(regWrite),
                     $sampled(writeRegAddr), $sampled(expPc), $sampled(expInstr),
                     $sampled(expRegWrite), $sampled(expDest));
        end

    // Order is halt, ctrlErr, memEnable, memWr, val2Reg, immSel
    controlsMatch: assert property (@(posedge clk) disable iff (reset)
        (checkOn && expValid) |-> {halt, ctrlErr, memEnable, memWr, val2Reg, immSel} ==
            {expHalt, expCtrlErr, expMemEn, expMemWr, expVal2Reg, expImmSel})
        else begin
            errCount++;
            $display("MISMATCH @%0t: controls %b, expected %b", $time,
                     $sampled({halt, ctrlErr, memEnable, memWr, val2Reg, immSel}),
                     $sampled({expHalt, expCtrlErr, expMemEn, expMemWr, expVal2Reg,
                               expImmSel}));
        end

    idleControls: assert property (@(posedge clk) disable iff (reset)
        (checkOn && !expValid) |-> !regWrite && !memEnable && !memWr && !halt &&
            !val2Reg && !ctrlErr && immSel == 3'd0)
        else begin
            errCount++;
            $display("MISMATCH @%0t: control active in a bubble cycle", $time);
        end

    function automatic logic [15:0] enc(input logic [4:0] op, input logic [2:0] a,
                                        input logic [2:0] b, input logic [4:0] c);
        return {op, a, b, c};
    endfunction

    // Reference field rules of the kept opcodes
    function automatic logic refWrites(input logic [15:0] w);
        return w[15:11] inside {OP_ADDI, OP_SUBI, OP_LD, OP_JAL, OP_RTYPE};
    endfunction

    function automatic logic [2:0] refDest(input logic [15:0] w);
        if (w[15:11] == OP_JAL) return 3'd7;
        if (w[15:11] == OP_RTYPE) return w[4:2];
        if (w[15:11] inside {OP_ADDI, OP_SUBI, OP_LD}) return w[7:5];
        return 3'd0;
    endfunction

    // Codes 1 to 3 pick the 5, 8 and 11-bit immediate fields
    function automatic logic [2:0] refImm(input logic [15:0] w);
        if (w[15:11] inside {OP_ADDI, OP_SUBI, OP_ST, OP_LD}) return 3'd1;
        if (w[15:11] inside {OP_BEQZ, OP_BNEZ}) return 3'd2;
        if (w[15:11] inside {OP_J, OP_JAL}) return 3'd3;
        return 3'd0;
    endfunction

    function automatic logic blocked(input logic [15:0] w);
        logic rs;
        logic rt;
        logic hit;
        rs = w[15:11] inside {OP_ADDI, OP_SUBI, OP_LD, OP_ST, OP_BEQZ, OP_BNEZ, OP_RTYPE};
        rt = w[15:11] inside {OP_ST, OP_RTYPE};
        hit = 1'b0;
        for (int e = 0; e < 2; e++) begin
            if (hWe[e] && ((rs && w[10:8] == hA[e]) || (rt && w[7:5] == hA[e]))) hit = 1'b1;
        end
        return hit;
    endfunction

    task automatic pushCycle(input int idx);
        expQ.push_back(idx);
        hWe[1] = hWe[0];
        hA[1] = hA[0];
        hWe[0] = (idx >= 0) ? refWrites(prog[idx]) : 1'b0;
        hA[0] = (idx >= 0) ? refDest(prog[idx]) : 3'd0;
    endtask

    task automatic addRun(input int from, input int upto);
        for (int i = from; i <= upto; i++) begin
            while (blocked(prog[i])) pushCycle(-1);
            pushCycle(i);
        end
    endtask

    task automatic resetDut();
        reset = 1'b1;
        dataReq = 1'b0;
        dataWr = 1'b0;
        pcSel = 1'b0;
        checkOn = 1'b0;
        quietPhase = 1'b0;
        dataPhase = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic dataOp(input logic wr, input logic [15:0] addr, input logic [15:0] val);
        dataReq = 1'b1;
        dataWr = wr;
        dataAddr = addr;
        dataWrData = val;
        if (wr) shadow[addr[8:1]] = val;
        else rdExpect = shadow[addr[8:1]];
        @(negedge clk);
    endtask

    task automatic report(input string name, input int errBefore);
        testCount++;
        $display("Test %-10s done, %0d errors", name, errCount - errBefore);
    endtask

    task automatic runDataTest();
        int errBefore;
        logic [15:0] first;
        logic [15:0] a;
        errBefore = errCount;
        resetDut();
        dataPhase = 1'b1;
        first = 16'(2 * ($urandom % 256));
        dataOp(1'b1, first, 16'($urandom));
        for (int i = 0; i < 12; i++) begin
            a = 16'(2 * ($urandom % 256));
            dataOp(1'b1, a, 16'($urandom));
            dataOp(1'b0, a, 16'h0);
            dataOp(1'b0, first, 16'h0);  // May have been overwritten meanwhile
        end
        dataOp(1'b1, first, 16'h0);
        dataReq = 1'b0;
        dataPhase = 1'b0;
        @(negedge clk);
        report("dataPort", errBefore);
    endtask

    task automatic runProgram(input string name, input int redirAt);
        int errBefore;
        int tgt;
        int idx;
        int haltIdx;
        errBefore = errCount;
        tgt = 0;
        haltIdx = prog.size() - 1;
        for (int i = prog.size() - 1; i >= 0; i--) begin
            if (prog[i][15:11] == OP_HALT) haltIdx = i;
        end
        expQ.delete();
        hWe[0] = 1'b0;
        hWe[1] = 1'b0;
        if (redirAt < 0) begin
            addRun(0, haltIdx);
        end else begin
            tgt = 8 + $urandom % 12;
            addRun(0, redirAt - 1);
            pushCycle(-2);  // Squashed word in the buffer
            pushCycle(-1);
            addRun(tgt, haltIdx);
        end
        repeat (6) pushCycle(-1);  // Nothing may follow HALT
        resetDut();
        quietPhase = 1'b1;
        foreach (prog[i]) begin
            dataOp(1'b1, 16'(2 * i), prog[i]);
        end
        dataReq = 1'b0;
        dataWr = 1'b0;
        @(negedge clk);  // Fetch of address 0
        quietPhase = 1'b0;
        brnchAddr = 16'(2 * tgt);
        foreach (expQ[k]) begin
            idx = expQ[k];
            checkOn = 1'b1;
            pcSel = (idx == -2);
            expValid = (idx >= 0);
            if (idx >= 0) begin
                expPc = 16'(2 * idx + 2);
                expInstr = prog[idx];
                expRegWrite = refWrites(prog[idx]);
                expDest = refDest(prog[idx]);
                expHalt = prog[idx][15:11] == OP_HALT;
                expCtrlErr = !(prog[idx][15:11] inside {OP_HALT, OP_NOP, OP_J, OP_JAL,
                    OP_ADDI, OP_SUBI, OP_BEQZ, OP_BNEZ, OP_ST, OP_LD, OP_RTYPE});
                expMemEn = prog[idx][15:11] inside {OP_LD, OP_ST};
                expMemWr = prog[idx][15:11] == OP_ST;
                expVal2Reg = prog[idx][15:11] == OP_LD;
                expImmSel = refImm(prog[idx]);
            end
            @(negedge clk);
        end
        checkOn = 1'b0;
        pcSel = 1'b0;
        report(name, errBefore);
    endtask

    initial begin
        errCount = 0;
        testCount = 0;
        dataAddr = 16'h0;
        dataWrData = 16'h0;
        brnchAddr = 16'h0;
        rdExpect = 16'h0;
        expValid = 1'b0;
        void'($urandom(66));
        resetDut();

        runDataTest();

        prog = '{enc(OP_ADDI, 0, 1, 3), enc(OP_ADDI, 0, 2, 1), enc(OP_RTYPE, 0, 0, 5'b01100),
                 enc(OP_JAL, 0, 0, 4), enc(OP_LD, 4, 5, 2), enc(OP_ST, 6, 6, 0),
                 enc(OP_BEQZ, 1, 0, 8), enc(OP_SUBI, 2, 4, 1), 16'h0800, 16'h0000};
        runProgram("independent", -1);

        // Distance one and then distance two through a NOP
        prog = '{enc(OP_ADDI, 0, 1, 1), enc(OP_ADDI, 1, 2, 1), 16'h0800,
                 enc(OP_ADDI, 2, 3, 1), enc(OP_RTYPE, 0, 3, 5'b10000),
                 enc(OP_LD, 4, 5, 0), enc(OP_ST, 0, 5, 0), 16'h0000};
        runProgram("dependence", -1);

        prog.delete();
        for (int i = 0; i < lenRedir - 1; i++) begin
            prog.push_back((i % 3 == 0) ? enc(OP_JAL, 0, 0, 5'(i)) : (16'h0800 | 16'(i)));
        end
        prog.push_back(16'h0000);
        runProgram("redirect", 5);

        prog = '{enc(OP_ADDI, 0, 1, 2), {5'b11111, 3'd1, 3'd1, 5'd0},
                 enc(OP_ST, 1, 2, 0), 16'h0000, enc(OP_ADDI, 0, 2, 1)};
        runProgram("haltIllegal", -1);

        $display("Tests run: %0d, errors: %0d", testCount, errCount);
        if (errCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (runCycles) @(posedge clk);
        $display("Watchdog expired before all tests finished");
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire
